// ==== src/pmem_consts.svh ====
`ifndef PMEM_CONSTS_SVH
`define PMEM_CONSTS_SVH

// input and output interface count
`define PMEM_PORTS 4

// stream word width in bits
`define PMEM_DATA_W 64

// buffer address, 4096 words per input
`define PMEM_ADDR_W 12

// tag width, 64 stored packets per input
`define PMEM_TAG_W 6

// packet length in words
`define PMEM_LEN_W 6

// read commands held per output
`define PMEM_CMDQ_DEPTH 8

`endif

// ==== src/pmem_pkg.sv ====
`default_nettype none

`include "pmem_consts.svh"

package pmem_pkg;

	// selects one interface
	typedef logic [$clog2(`PMEM_PORTS)-1:0] port_sel_t;

	// unused bytes in the last word of a packet
	typedef logic [2:0] empty_t;

	// match result from the match engine
	typedef struct packed {
		port_sel_t dest;
		port_sel_t src;
		logic [`PMEM_TAG_W-1:0] tag;
	} match_word_t;

	// one stored packet to send out
	typedef struct packed {
		empty_t empty;
		port_sel_t src;
		logic [`PMEM_ADDR_W-1:0] start_address;
		logic [`PMEM_LEN_W-1:0] length;
	} read_cmd_t;

endpackage

`default_nettype wire

// ==== src/pmem_ingress.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pmem_consts.svh"

module pmem_ingress (
	input wire logic clock,
	input wire logic reset,
	input wire logic [`PMEM_DATA_W-1:0] packetin_data,
	input wire logic packetin_valid,
	input wire logic packetin_sop,
	input wire logic packetin_eop,
	input wire pmem_pkg::empty_t packetin_empty,
	output logic packetin_ready,
	output logic [`PMEM_DATA_W-1:0] packetout_data,
	output logic packetout_valid,
	output logic packetout_sop,
	output logic packetout_eop,
	output logic [`PMEM_TAG_W-1:0] packetout_channel,
	input wire logic packetout_ready,
	input wire logic [`PMEM_TAG_W-1:0] table_tag,
	output pmem_pkg::read_cmd_t table_entry,
	input wire logic [`PMEM_ADDR_W-1:0] read_address [`PMEM_PORTS],
	output logic [`PMEM_DATA_W-1:0] read_data [`PMEM_PORTS]
);

	import pmem_pkg::*;

	localparam int BUFFER_DEPTH = 1 << `PMEM_ADDR_W;
	localparam int TABLE_DEPTH = 1 << `PMEM_TAG_W;

	logic accept;
	logic [`PMEM_ADDR_W-1:0] write_address;
	logic [`PMEM_ADDR_W-1:0] start_address;
	logic [`PMEM_ADDR_W-1:0] packet_start;
	logic [`PMEM_LEN_W-1:0] length_count;
	logic [`PMEM_TAG_W-1:0] tag;

	logic [`PMEM_DATA_W-1:0] buffer [BUFFER_DEPTH];
	logic [`PMEM_ADDR_W+`PMEM_LEN_W-1:0] packet_table [TABLE_DEPTH];
	empty_t empty_table [TABLE_DEPTH];

	logic [`PMEM_ADDR_W-1:0] entry_start;
	logic [`PMEM_LEN_W-1:0] entry_length;
	empty_t entry_empty;

	// passthrough, the channel is the tag this packet will get
	assign packetin_ready = packetout_ready;
	assign packetout_data = packetin_data;
	assign packetout_valid = packetin_valid;
	assign packetout_sop = packetin_sop;
	assign packetout_eop = packetin_eop;
	assign packetout_channel = tag;

	assign accept = packetin_valid && packetout_ready;

	// single word packets start at the current address
	assign packet_start = packetin_sop ? write_address : start_address;

	always_ff @(posedge clock) begin
		if (reset) begin
			write_address <= '0;
			start_address <= '0;
			length_count <= `PMEM_LEN_W'(1);
			tag <= '0;
		end else if (accept) begin
			write_address <= write_address + 1'b1;
			if (packetin_sop)
				start_address <= write_address;
			if (packetin_eop) begin
				length_count <= `PMEM_LEN_W'(1);
				tag <= tag + 1'b1;
			end else begin
				length_count <= length_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			buffer[write_address] <= packetin_data;
	end

	// one registered read port per output
	for (genvar j = 0; j < `PMEM_PORTS; j++) begin : g_read_port
		always_ff @(posedge clock) begin
			read_data[j] <= buffer[read_address[j]];
		end
	end

	// table entry written on the eop transfer
	always_ff @(posedge clock) begin
		if (accept && packetin_eop) begin
			packet_table[tag] <= {packet_start, length_count};
			empty_table[tag] <= packetin_empty;
		end
	end

	always_ff @(posedge clock) begin
		{entry_start, entry_length} <= packet_table[table_tag];
		entry_empty <= empty_table[table_tag];
	end

	// src is filled in by the decoder
	always_comb begin
		table_entry.empty = entry_empty;
		table_entry.src = '0;
		table_entry.start_address = entry_start;
		table_entry.length = entry_length;
	end

	// a 64 word packet would wrap the counter to zero
	assert property (@(posedge clock) disable iff (reset)
		accept && packetin_eop |-> length_count != '0)
		else $error("packet longer than the length counter range");

endmodule

`default_nettype wire

// ==== src/pmem_match_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pmem_consts.svh"

module pmem_match_decode (
	input wire logic clock,
	input wire logic reset,
	input wire pmem_pkg::match_word_t tagin_data,
	input wire logic tagin_valid,
	output logic tagin_ready,
	output logic [`PMEM_TAG_W-1:0] table_tag,
	input wire pmem_pkg::read_cmd_t table_entry [`PMEM_PORTS],
	input wire logic queue_full [`PMEM_PORTS],
	output logic queue_push [`PMEM_PORTS],
	output pmem_pkg::read_cmd_t queue_command
);

	import pmem_pkg::*;

	logic started;
	logic any_full;
	logic advance;
	match_word_t lookup_word;
	logic lookup_valid;
	match_word_t select_word;
	logic select_valid;

	always_comb begin
		any_full = 1'b0;
		for (int i = 0; i < `PMEM_PORTS; i++)
			any_full = any_full | queue_full[i];
	end

	// a word waiting on a full queue holds both stages
	assign advance = !(select_valid && queue_full[select_word.dest]);
	assign tagin_ready = started && !any_full;

	// re-read the held word's entry while stalled
	assign table_tag = advance ? lookup_word.tag : select_word.tag;

	always_ff @(posedge clock) begin
		if (reset) begin
			started <= 1'b0;
			lookup_valid <= 1'b0;
			select_valid <= 1'b0;
		end else begin
			started <= 1'b1;
			if (advance) begin
				lookup_valid <= tagin_valid && tagin_ready;
				select_valid <= lookup_valid;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			lookup_word <= tagin_data;
			select_word <= lookup_word;
		end
	end

	always_comb begin
		queue_command = table_entry[select_word.src];
		queue_command.src = select_word.src;
	end

	for (genvar j = 0; j < `PMEM_PORTS; j++) begin : g_push
		assign queue_push[j] = select_valid && select_word.dest == j && !queue_full[j];
	end

endmodule

`default_nettype wire

// ==== src/pmem_cmd_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pmem_consts.svh"

module pmem_cmd_queue #(
	parameter int WIDTH = 23
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic push,
	input wire logic [WIDTH-1:0] push_data,
	input wire logic pop,
	output logic [WIDTH-1:0] pop_data,
	output logic empty,
	output logic full
);

	localparam int DEPTH = `PMEM_CMDQ_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	logic [WIDTH-1:0] entries [DEPTH];
	logic [PTR_W-1:0] write_ptr;
	logic [PTR_W-1:0] read_ptr;
	logic [PTR_W:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign empty = count == '0;
	assign full = count == (PTR_W+1)'(DEPTH);

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			write_ptr <= '0;
			read_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				write_ptr <= write_ptr + 1'b1;
			if (do_pop)
				read_ptr <= read_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			entries[write_ptr] <= push_data;
		if (do_pop)
			pop_data <= entries[read_ptr];
	end

	assert property (@(posedge clock) disable iff (reset) push |-> !full)
		else $error("command queue overflow");

	assert property (@(posedge clock) disable iff (reset) pop |-> !empty)
		else $error("command queue underflow");

endmodule

`default_nettype wire

// ==== src/pmem_transmit_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pmem_consts.svh"

module pmem_transmit_reader (
	input wire logic clock,
	input wire logic reset,
	input wire pmem_pkg::read_cmd_t queue_data,
	input wire logic queue_empty,
	input wire logic stall,
	output logic queue_pop,
	output logic [`PMEM_ADDR_W-1:0] read_address,
	output pmem_pkg::port_sel_t read_source,
	output logic read_valid,
	output logic read_first,
	output logic read_last,
	output pmem_pkg::empty_t packet_empty
);

	import pmem_pkg::*;

	logic pop_pending;
	logic first;
	logic [`PMEM_LEN_W-1:0] remaining;
	logic [`PMEM_ADDR_W-1:0] address;
	port_sel_t source;
	empty_t empty_bytes;

	// queue data shows up the cycle after the pop
	assign queue_pop = remaining == '0 && !queue_empty && !pop_pending;

	assign read_valid = remaining != '0 && !stall;
	assign read_address = address;
	assign read_source = source;
	assign read_first = first;
	assign read_last = remaining == `PMEM_LEN_W'(1);
	assign packet_empty = empty_bytes;

	always_ff @(posedge clock) begin
		if (reset) begin
			pop_pending <= 1'b0;
			remaining <= '0;
			first <= 1'b0;
		end else begin
			pop_pending <= queue_pop;
			if (pop_pending) begin
				remaining <= queue_data.length;
				first <= 1'b1;
			end else if (read_valid) begin
				remaining <= remaining - 1'b1;
				first <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (pop_pending) begin
			address <= queue_data.start_address;
			source <= queue_data.src;
			empty_bytes <= queue_data.empty;
		end else if (read_valid) begin
			// packets may straddle the end of the buffer
			address <= address + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/pmem_output_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pmem_consts.svh"

module pmem_output_framer (
	input wire logic clock,
	input wire logic reset,
	input wire logic [`PMEM_DATA_W-1:0] read_data [`PMEM_PORTS],
	input wire pmem_pkg::port_sel_t read_source,
	input wire logic read_valid,
	input wire logic read_first,
	input wire logic read_last,
	input wire pmem_pkg::empty_t packet_empty,
	input wire logic transmitout_ready,
	output logic stall,
	output logic [`PMEM_DATA_W-1:0] transmitout_data,
	output logic transmitout_valid,
	output logic transmitout_sop,
	output logic transmitout_eop,
	output pmem_pkg::empty_t transmitout_empty
);

	import pmem_pkg::*;

	localparam int HOLD_DEPTH = 4;
	localparam int PTR_W = $clog2(HOLD_DEPTH);

	logic data_valid;
	logic data_sop;
	logic data_eop;
	port_sel_t data_source;
	empty_t data_empty;

	logic [`PMEM_DATA_W-1:0] hold_data [HOLD_DEPTH];
	logic hold_sop [HOLD_DEPTH];
	logic hold_eop [HOLD_DEPTH];
	empty_t hold_empty [HOLD_DEPTH];
	logic [PTR_W-1:0] write_ptr;
	logic [PTR_W-1:0] read_ptr;
	logic [PTR_W:0] count;
	logic do_pop;

	assign transmitout_valid = count != '0;
	assign do_pop = transmitout_valid && transmitout_ready;

	// two reads can still be in flight when this rises
	assign stall = count >= (PTR_W+1)'(HOLD_DEPTH - 2);

	assign transmitout_data = hold_data[read_ptr];
	assign transmitout_sop = hold_sop[read_ptr];
	assign transmitout_eop = hold_eop[read_ptr];
	assign transmitout_empty = hold_empty[read_ptr];

	// qualifiers lag one cycle to line up with buffer data
	always_ff @(posedge clock) begin
		if (reset)
			data_valid <= 1'b0;
		else
			data_valid <= read_valid;
	end

	always_ff @(posedge clock) begin
		data_sop <= read_first;
		data_eop <= read_last;
		data_source <= read_source;
		data_empty <= read_last ? packet_empty : '0;
	end

	always_ff @(posedge clock) begin
		if (data_valid) begin
			hold_data[write_ptr] <= read_data[data_source];
			hold_sop[write_ptr] <= data_sop;
			hold_eop[write_ptr] <= data_eop;
			hold_empty[write_ptr] <= data_empty;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			write_ptr <= '0;
			read_ptr <= '0;
			count <= '0;
		end else begin
			if (data_valid)
				write_ptr <= write_ptr + 1'b1;
			if (do_pop)
				read_ptr <= read_ptr + 1'b1;
			case ({data_valid, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the reader must have seen stall in time
	assert property (@(posedge clock) disable iff (reset)
		data_valid |-> count != (PTR_W+1)'(HOLD_DEPTH))
		else $error("framer holding buffer overflow");

endmodule

`default_nettype wire

// ==== src/pmem_group.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pmem_consts.svh"

module pmem_group (
	input wire logic clock,
	input wire logic reset,
	input wire logic [`PMEM_DATA_W-1:0] packetin_data [`PMEM_PORTS],
	input wire logic packetin_valid [`PMEM_PORTS],
	input wire logic packetin_sop [`PMEM_PORTS],
	input wire logic packetin_eop [`PMEM_PORTS],
	input wire pmem_pkg::empty_t packetin_empty [`PMEM_PORTS],
	output logic packetin_ready [`PMEM_PORTS],
	output logic [`PMEM_DATA_W-1:0] packetout_data [`PMEM_PORTS],
	output logic packetout_valid [`PMEM_PORTS],
	output logic packetout_sop [`PMEM_PORTS],
	output logic packetout_eop [`PMEM_PORTS],
	output logic [`PMEM_TAG_W-1:0] packetout_channel [`PMEM_PORTS],
	input wire logic packetout_ready [`PMEM_PORTS],
	output logic [`PMEM_DATA_W-1:0] transmitout_data [`PMEM_PORTS],
	output logic transmitout_valid [`PMEM_PORTS],
	output logic transmitout_sop [`PMEM_PORTS],
	output logic transmitout_eop [`PMEM_PORTS],
	output pmem_pkg::empty_t transmitout_empty [`PMEM_PORTS],
	input wire logic transmitout_ready [`PMEM_PORTS],
	input wire pmem_pkg::match_word_t tagin_data,
	input wire logic tagin_valid,
	output logic tagin_ready
);

	import pmem_pkg::*;

	logic [`PMEM_TAG_W-1:0] table_tag;
	read_cmd_t table_entry [`PMEM_PORTS];
	read_cmd_t queue_command;
	logic queue_push [`PMEM_PORTS];
	logic queue_full [`PMEM_PORTS];
	logic queue_empty [`PMEM_PORTS];
	logic queue_pop [`PMEM_PORTS];
	read_cmd_t queue_data [`PMEM_PORTS];

	logic [`PMEM_ADDR_W-1:0] read_address [`PMEM_PORTS];
	port_sel_t read_source [`PMEM_PORTS];
	logic read_valid [`PMEM_PORTS];
	logic read_first [`PMEM_PORTS];
	logic read_last [`PMEM_PORTS];
	empty_t packet_empty [`PMEM_PORTS];
	logic stall [`PMEM_PORTS];

	// buffer_data is [input][output], framer_data is [output][input]
	logic [`PMEM_DATA_W-1:0] buffer_data [`PMEM_PORTS][`PMEM_PORTS];
	wire logic [`PMEM_DATA_W-1:0] framer_data [`PMEM_PORTS][`PMEM_PORTS];

	for (genvar i = 0; i < `PMEM_PORTS; i++) begin : g_input
		pmem_ingress i_ingress (
			.clock(clock),
			.reset(reset),
			.packetin_data(packetin_data[i]),
			.packetin_valid(packetin_valid[i]),
			.packetin_sop(packetin_sop[i]),
			.packetin_eop(packetin_eop[i]),
			.packetin_empty(packetin_empty[i]),
			.packetin_ready(packetin_ready[i]),
			.packetout_data(packetout_data[i]),
			.packetout_valid(packetout_valid[i]),
			.packetout_sop(packetout_sop[i]),
			.packetout_eop(packetout_eop[i]),
			.packetout_channel(packetout_channel[i]),
			.packetout_ready(packetout_ready[i]),
			.table_tag(table_tag),
			.table_entry(table_entry[i]),
			.read_address(read_address),
			.read_data(buffer_data[i])
		);

		for (genvar j = 0; j < `PMEM_PORTS; j++) begin : g_cross
			assign framer_data[j][i] = buffer_data[i][j];
		end
	end

	pmem_match_decode i_match_decode (
		.clock(clock),
		.reset(reset),
		.tagin_data(tagin_data),
		.tagin_valid(tagin_valid),
		.tagin_ready(tagin_ready),
		.table_tag(table_tag),
		.table_entry(table_entry),
		.queue_full(queue_full),
		.queue_push(queue_push),
		.queue_command(queue_command)
	);

	for (genvar j = 0; j < `PMEM_PORTS; j++) begin : g_output
		pmem_cmd_queue #(
			.WIDTH($bits(read_cmd_t))
		) i_cmd_queue (
			.clock(clock),
			.reset(reset),
			.push(queue_push[j]),
			.push_data(queue_command),
			.pop(queue_pop[j]),
			.pop_data(queue_data[j]),
			.empty(queue_empty[j]),
			.full(queue_full[j])
		);

		pmem_transmit_reader i_transmit_reader (
			.clock(clock),
			.reset(reset),
			.queue_data(queue_data[j]),
			.queue_empty(queue_empty[j]),
			.stall(stall[j]),
			.queue_pop(queue_pop[j]),
			.read_address(read_address[j]),
			.read_source(read_source[j]),
			.read_valid(read_valid[j]),
			.read_first(read_first[j]),
			.read_last(read_last[j]),
			.packet_empty(packet_empty[j])
		);

		pmem_output_framer i_output_framer (
			.clock(clock),
			.reset(reset),
			.read_data(framer_data[j]),
			.read_source(read_source[j]),
			.read_valid(read_valid[j]),
			.read_first(read_first[j]),
			.read_last(read_last[j]),
			.packet_empty(packet_empty[j]),
			.transmitout_ready(transmitout_ready[j]),
			.stall(stall[j]),
			.transmitout_data(transmitout_data[j]),
			.transmitout_valid(transmitout_valid[j]),
			.transmitout_sop(transmitout_sop[j]),
			.transmitout_eop(transmitout_eop[j]),
			.transmitout_empty(transmitout_empty[j])
		);
	end

endmodule

`default_nettype wire

// ==== dv/pmem_group_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pmem_consts.svh"

module pmem_group_checker (
	input wire logic clock,
	input wire logic reset,
	input wire logic [`PMEM_DATA_W-1:0] packetin_data [`PMEM_PORTS],
	input wire logic packetin_valid [`PMEM_PORTS],
	input wire logic packetin_sop [`PMEM_PORTS],
	input wire logic packetin_eop [`PMEM_PORTS],
	input wire pmem_pkg::empty_t packetin_empty [`PMEM_PORTS],
	input wire logic packetin_ready [`PMEM_PORTS],
	input wire logic [`PMEM_DATA_W-1:0] packetout_data [`PMEM_PORTS],
	input wire logic packetout_valid [`PMEM_PORTS],
	input wire logic packetout_sop [`PMEM_PORTS],
	input wire logic packetout_eop [`PMEM_PORTS],
	input wire logic [`PMEM_TAG_W-1:0] packetout_channel [`PMEM_PORTS],
	input wire logic packetout_ready [`PMEM_PORTS],
	input wire logic [`PMEM_DATA_W-1:0] transmitout_data [`PMEM_PORTS],
	input wire logic transmitout_valid [`PMEM_PORTS],
	input wire logic transmitout_sop [`PMEM_PORTS],
	input wire logic transmitout_eop [`PMEM_PORTS],
	input wire pmem_pkg::empty_t transmitout_empty [`PMEM_PORTS],
	input wire logic transmitout_ready [`PMEM_PORTS],
	input wire pmem_pkg::match_word_t tagin_data,
	input wire logic tagin_valid,
	input wire logic tagin_ready,
	output int value_errors,
	output int other_errors,
	output int pending
);

	import pmem_pkg::*;

	localparam int MAX_WORDS = 16;
	localparam int TAGS = 1 << `PMEM_TAG_W;
	localparam int RING = 256;

	// every stored packet by input and tag
	logic [`PMEM_DATA_W-1:0] stored_data [`PMEM_PORTS][TAGS][MAX_WORDS];
	int stored_length [`PMEM_PORTS][TAGS];
	empty_t stored_empty [`PMEM_PORTS][TAGS];
	logic [`PMEM_DATA_W-1:0] current_data [`PMEM_PORTS][MAX_WORDS];
	int current_length [`PMEM_PORTS];
	logic [`PMEM_TAG_W-1:0] expected_channel [`PMEM_PORTS];

	// expected packets of each output in match acceptance order
	int expected_src [`PMEM_PORTS][RING];
	int expected_tag [`PMEM_PORTS][RING];
	int head [`PMEM_PORTS];
	int tail [`PMEM_PORTS];
	int word_index [`PMEM_PORTS];

	logic held_valid [`PMEM_PORTS];
	logic [`PMEM_DATA_W-1:0] held_data [`PMEM_PORTS];
	logic held_sop [`PMEM_PORTS];
	logic held_eop [`PMEM_PORTS];
	empty_t held_empty [`PMEM_PORTS];
	logic match_seen;
	logic after_reset;

	task automatic value_error(input string message);
		$display("FAILED %0t: %s", $time, message);
		value_errors++;
	endtask

	task automatic other_error(input string message);
		$display("error at %0t: %s", $time, message);
		other_errors++;
	endtask

	// a command queue fills only once its output has that many packets outstanding
	function automatic logic backlog_reached();
		logic reached;
		reached = 1'b0;
		for (int o = 0; o < `PMEM_PORTS; o++)
			if (tail[o] - head[o] >= `PMEM_CMDQ_DEPTH)
				reached = 1'b1;
		return reached;
	endfunction

	task automatic check_input(input int p);
		if (packetin_ready[p] !== packetout_ready[p])
			value_error($sformatf("input %0d ready does not follow packetout_ready", p));
		if (packetout_valid[p] !== packetin_valid[p])
			value_error($sformatf("input %0d passthrough valid differs", p));
		if (packetin_valid[p] && (packetout_data[p] !== packetin_data[p] ||
				packetout_sop[p] !== packetin_sop[p] || packetout_eop[p] !== packetin_eop[p]))
			value_error($sformatf("input %0d passthrough word %h, expected %h",
				p, packetout_data[p], packetin_data[p]));
		if (packetin_valid[p] && packetin_ready[p]) begin
			if (packetout_channel[p] !== expected_channel[p])
				value_error($sformatf("input %0d channel %0d, expected %0d",
					p, packetout_channel[p], expected_channel[p]));
			if (packetin_sop[p])
				current_length[p] = 0;
			current_data[p][current_length[p]] = packetin_data[p];
			current_length[p]++;
			if (packetin_eop[p]) begin
				for (int w = 0; w < current_length[p]; w++)
					stored_data[p][expected_channel[p]][w] = current_data[p][w];
				stored_length[p][expected_channel[p]] = current_length[p];
				stored_empty[p][expected_channel[p]] = packetin_empty[p];
				expected_channel[p]++;
			end
		end
	endtask

	task automatic record_match();
		match_word_t word;
		word = tagin_data;
		if (stored_length[word.src][word.tag] == 0)
			other_error($sformatf("match word names packet %0d of input %0d, never stored",
				word.tag, word.src));
		expected_src[word.dest][tail[word.dest] % RING] = word.src;
		expected_tag[word.dest][tail[word.dest] % RING] = word.tag;
		tail[word.dest]++;
		pending++;
		match_seen = 1'b1;
	endtask

	task automatic check_output(input int o);
		int slot;
		int src;
		int tag;
		int length;
		logic last;
		empty_t empty_expect;
		if (held_valid[o] && (!transmitout_valid[o] || transmitout_data[o] !== held_data[o] ||
				transmitout_sop[o] !== held_sop[o] || transmitout_eop[o] !== held_eop[o] ||
				transmitout_empty[o] !== held_empty[o]))
			value_error($sformatf("output %0d word changed while ready was low", o));
		if (transmitout_valid[o] && !match_seen)
			other_error($sformatf("output %0d went valid before any match word", o));
		if (transmitout_valid[o] && transmitout_ready[o]) begin
			if (head[o] == tail[o]) begin
				other_error($sformatf("output %0d sent a word with no packet expected", o));
			end else begin
				slot = head[o] % RING;
				src = expected_src[o][slot];
				tag = expected_tag[o][slot];
				length = stored_length[src][tag];
				last = word_index[o] == length - 1;
				empty_expect = last ? stored_empty[src][tag] : '0;
				if (transmitout_data[o] !== stored_data[src][tag][word_index[o]])
					value_error($sformatf("output %0d word %0d data %h, expected %h", o,
						word_index[o], transmitout_data[o], stored_data[src][tag][word_index[o]]));
				if (transmitout_sop[o] !== (word_index[o] == 0))
					value_error($sformatf("output %0d word %0d sop wrong", o, word_index[o]));
				if (transmitout_eop[o] !== last)
					value_error($sformatf("output %0d word %0d eop wrong", o, word_index[o]));
				if (transmitout_empty[o] !== empty_expect)
					value_error($sformatf("output %0d empty %0d, expected %0d",
						o, transmitout_empty[o], empty_expect));
				word_index[o]++;
				if (last) begin
					word_index[o] = 0;
					head[o]++;
					pending--;
				end
			end
		end
		held_valid[o] = transmitout_valid[o] && !transmitout_ready[o];
		held_data[o] = transmitout_data[o];
		held_sop[o] = transmitout_sop[o];
		held_eop[o] = transmitout_eop[o];
		held_empty[o] = transmitout_empty[o];
	endtask

	always @(posedge clock) begin
		if (reset) begin
			for (int p = 0; p < `PMEM_PORTS; p++) begin
				for (int t = 0; t < TAGS; t++)
					stored_length[p][t] = 0;
				current_length[p] = 0;
				expected_channel[p] = '0;
				head[p] = 0;
				tail[p] = 0;
				word_index[p] = 0;
				held_valid[p] = 1'b0;
			end
			value_errors = 0;
			other_errors = 0;
			pending = 0;
			match_seen = 1'b0;
			after_reset = 1'b1;
		end else begin
			// decoder holds off match words for a cycle after reset
			if (after_reset) begin
				if (tagin_ready)
					other_error("tagin_ready was high in the first cycle after reset");
			end else if (!tagin_ready && !backlog_reached()) begin
				value_error("tagin_ready low while no command queue can be full");
			end
			after_reset = 1'b0;
			for (int p = 0; p < `PMEM_PORTS; p++)
				check_input(p);
			if (tagin_valid && tagin_ready)
				record_match();
			for (int o = 0; o < `PMEM_PORTS; o++)
				check_output(o);
		end
	end

endmodule

`default_nettype wire

// ==== dv/pmem_group_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pmem_consts.svh"

module pmem_group_tb;

	import pmem_pkg::*;

	localparam int ROUNDS = 8;
	localparam int PACKETS = 16;
	localparam int MAX_WORDS = 16;
	localparam int WATCHDOG_NS = ROUNDS * PACKETS * MAX_WORDS * 40;
	localparam int TAGS = 1 << `PMEM_TAG_W;

	logic clock;
	logic reset;
	logic [`PMEM_DATA_W-1:0] packetin_data [`PMEM_PORTS];
	logic packetin_valid [`PMEM_PORTS];
	logic packetin_sop [`PMEM_PORTS];
	logic packetin_eop [`PMEM_PORTS];
	empty_t packetin_empty [`PMEM_PORTS];
	logic packetin_ready [`PMEM_PORTS];
	logic [`PMEM_DATA_W-1:0] packetout_data [`PMEM_PORTS];
	logic packetout_valid [`PMEM_PORTS];
	logic packetout_sop [`PMEM_PORTS];
	logic packetout_eop [`PMEM_PORTS];
	logic [`PMEM_TAG_W-1:0] packetout_channel [`PMEM_PORTS];
	logic packetout_ready [`PMEM_PORTS];
	logic [`PMEM_DATA_W-1:0] transmitout_data [`PMEM_PORTS];
	logic transmitout_valid [`PMEM_PORTS];
	logic transmitout_sop [`PMEM_PORTS];
	logic transmitout_eop [`PMEM_PORTS];
	empty_t transmitout_empty [`PMEM_PORTS];
	logic transmitout_ready [`PMEM_PORTS];
	match_word_t tagin_data;
	logic tagin_valid;
	logic tagin_ready;

	integer seed;
	int sent [`PMEM_PORTS];
	int next_tag [`PMEM_PORTS];
	int value_errors;
	int other_errors;
	int pending;

	pmem_group i_pmem_group (.*);

	pmem_group_checker i_checker (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// random back-pressure on both streams
	always @(posedge clock) begin
		for (int p = 0; p < `PMEM_PORTS; p++) begin
			packetout_ready[p] <= !reset && (($random(seed) & 3) != 0);
			transmitout_ready[p] <= !reset && (($random(seed) & 3) != 0);
		end
	end

	task automatic send_packet(input int p);
		int words;
		words = 1 + {$random(seed)} % MAX_WORDS;
		for (int w = 0; w < words; w++) begin
			while (({$random(seed)} % 4) == 0) begin
				packetin_valid[p] <= 1'b0;
				@(posedge clock);
			end
			packetin_valid[p] <= 1'b1;
			packetin_data[p] <= {$random(seed), $random(seed)};
			packetin_sop[p] <= w == 0;
			packetin_eop[p] <= w == words - 1;
			packetin_empty[p] <= empty_t'($random(seed));
			@(posedge clock);
			while (!packetin_ready[p])
				@(posedge clock);
		end
		packetin_valid[p] <= 1'b0;
	endtask

	task automatic send_round(input int p, input int count);
		for (int k = 0; k < count; k++)
			send_packet(p);
	endtask

	task automatic send_match(input int src, input int tag);
		match_word_t word;
		word.dest = port_sel_t'($random(seed));
		word.src = port_sel_t'(src);
		word.tag = `PMEM_TAG_W'(tag);
		tagin_data <= word;
		tagin_valid <= 1'b1;
		@(posedge clock);
		while (!tagin_ready)
			@(posedge clock);
		tagin_valid <= 1'b0;
	endtask

	// one match word per packet of this round
	task automatic issue_matches();
		for (int k = 0; k < PACKETS; k++)
			for (int p = 0; p < `PMEM_PORTS; p++)
				if (k < sent[p])
					send_match(p, (next_tag[p] + k) % TAGS);
		for (int p = 0; p < `PMEM_PORTS; p++)
			next_tag[p] = (next_tag[p] + sent[p]) % TAGS;
	endtask

	initial begin
		seed = 32'hd546_d164;
		reset = 1'b1;
		tagin_data = '0;
		tagin_valid = 1'b0;
		for (int p = 0; p < `PMEM_PORTS; p++) begin
			packetin_data[p] = '0;
			packetin_valid[p] = 1'b0;
			packetin_sop[p] = 1'b0;
			packetin_eop[p] = 1'b0;
			packetin_empty[p] = '0;
			packetout_ready[p] = 1'b0;
			transmitout_ready[p] = 1'b0;
			next_tag[p] = 0;
		end
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		for (int r = 0; r < ROUNDS; r++) begin
			for (int p = 0; p < `PMEM_PORTS; p++)
				sent[p] = PACKETS / 2 + {$random(seed)} % (PACKETS / 2 + 1);
			fork
				send_round(0, sent[0]);
				send_round(1, sent[1]);
				send_round(2, sent[2]);
				send_round(3, sent[3]);
			join
			issue_matches();
			// drain before the next round reuses tags
			do
				@(negedge clock);
			while (pending != 0);
			@(posedge clock);
		end
		repeat (20) @(posedge clock);
		@(negedge clock);
		$display("errors: %0d wrong values, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish, %0d packets never transmitted", pending);
		$display("errors: %0d wrong values, %0d other", value_errors, other_errors);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pmem_group.f ====
+incdir+src
src/pmem_pkg.sv
src/pmem_ingress.sv
src/pmem_match_decode.sv
src/pmem_cmd_queue.sv
src/pmem_transmit_reader.sv
src/pmem_output_framer.sv
src/pmem_group.sv
dv/pmem_group_checker.sv
dv/pmem_group_tb.sv

// ==== Bender.yml ====
package:
  name: pmem_group

sources:
  - include_dirs:
      - src
    files:
      - src/pmem_pkg.sv
      - src/pmem_ingress.sv
      - src/pmem_match_decode.sv
      - src/pmem_cmd_queue.sv
      - src/pmem_transmit_reader.sv
      - src/pmem_output_framer.sv
      - src/pmem_group.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/pmem_group_checker.sv
      - dv/pmem_group_tb.sv
